// ==== filelist.f ====
hdl/lcd_pkg.sv
hdl/lcd_axi_slave.sv
hdl/lcd_graph_buffer.sv
hdl/lcd_dispatch.sv
hdl/lcd_ctrl.sv
verif/lcd_id_model.sv
verif/lcd_ctrl_tb.sv

// ==== hdl/lcd_axi_slave.sv ====
// single-beat AXI slave; wlast and all id/burst fields are ignored
// partial-strobe writes get OKAY but are not forwarded as commands
`timescale 1ns/1ps
`default_nettype none

module lcd_axi_slave (
    input  wire logic                        pclk,
    input  wire logic                        rst_n,
    input  wire lcd_pkg::axi_addr_t          aw_i,
    input  wire logic                        awvalid_i,
    output logic                             awready_o,
    input  wire lcd_pkg::axi_w_t             w_i,
    input  wire logic                        wvalid_i,
    output logic                             wready_o,
    output lcd_pkg::axi_b_t                  b_o,
    output logic                             bvalid_o,
    input  wire logic                        bready_i,
    input  wire lcd_pkg::axi_addr_t          ar_i,
    input  wire logic                        arvalid_i,
    output logic                             arready_o,
    output lcd_pkg::axi_r_t                  r_o,
    output logic                             rvalid_o,
    input  wire logic                        rready_i,
    input  wire logic [lcd_pkg::DATA_W-1:0]  touch_reg_i,
    input  wire logic                        busy_i,
    output lcd_pkg::lcd_cmd_t                wr_cmd_o,
    output logic                             wr_valid_o
);
    import lcd_pkg::*;

    typedef enum logic {R_ADDR, R_DATA} r_state_e;
    typedef enum logic [1:0] {W_IDLE, W_ADDR, W_DATA, W_RESP} w_state_e;

    r_state_e          r_state;
    w_state_e          w_state;
    logic [DATA_W-1:0] rd_mux;
    logic [DATA_W-1:0] rdata_q;
    logic [ADDR_W-1:0] waddr_q;

    always_comb begin
        case (ar_i.addr)
            ADDR_LCD_INPUT:   rd_mux = touch_reg_i;
            ADDR_TOUCH_INPUT: rd_mux = '1;
            default:          rd_mux = '0;
        endcase
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            r_state   <= R_ADDR;
            arready_o <= 1'b1;
            rvalid_o  <= 1'b0;
        end else begin
            case (r_state)
                R_ADDR: if (arvalid_i && arready_o) begin
                    r_state   <= R_DATA;
                    arready_o <= 1'b0;
                    rvalid_o  <= 1'b1;
                end
                R_DATA: if (rvalid_o && rready_i) begin
                    r_state   <= R_ADDR;
                    arready_o <= 1'b1;
                    rvalid_o  <= 1'b0;
                end
                default: r_state <= R_ADDR;
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        if (arvalid_i && arready_o) rdata_q <= rd_mux;  // sampled with the address
    end

    assign r_o = '{data: rdata_q, resp: RESP_OKAY, last: 1'b1};
    assign b_o = '{resp: RESP_OKAY};

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            w_state    <= W_IDLE;
            awready_o  <= 1'b0;
            wready_o   <= 1'b0;
            bvalid_o   <= 1'b0;
            wr_valid_o <= 1'b0;
        end else begin
            wr_valid_o <= 1'b0;
            case (w_state)
                W_IDLE: if (!busy_i) begin  // hold off while a frame waits
                    w_state   <= W_ADDR;
                    awready_o <= 1'b1;
                end
                W_ADDR: if (awvalid_i && awready_o) begin
                    w_state   <= W_DATA;
                    awready_o <= 1'b0;
                    wready_o  <= 1'b1;
                end
                W_DATA: if (wvalid_i && wready_o) begin
                    w_state    <= W_RESP;
                    wready_o   <= 1'b0;
                    bvalid_o   <= 1'b1;
                    wr_valid_o <= (w_i.strb == STRB_FULL);
                end
                W_RESP: if (bvalid_o && bready_i) begin
                    w_state  <= W_IDLE;
                    bvalid_o <= 1'b0;
                end
                default: w_state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        if (awvalid_i && awready_o) waddr_q <= aw_i.addr;
        if (wvalid_i && wready_o) wr_cmd_o <= '{addr: waddr_q, data: w_i.data};
    end

    a_bvalid_hold: assert property (@(posedge pclk) disable iff (!rst_n)
        bvalid_o && !bready_i |=> bvalid_o);

    a_rvalid_hold: assert property (@(posedge pclk) disable iff (!rst_n)
        rvalid_o && !rready_i |=> rvalid_o && $stable(r_o));

    // busy must have closed the write path before a frame overflows
    a_no_write_when_busy: assert property (@(posedge pclk) disable iff (!rst_n)
        !(wr_valid_o && busy_i));

endmodule

`default_nettype wire

// ==== hdl/lcd_ctrl.sv ====
// lcd controller top: AXI slave, graph frame buffer and lcd_id dispatcher
// graph_size_o is meaningful only while a frame is being sent
`timescale 1ns/1ps
`default_nettype none

module lcd_ctrl (
    input  wire logic                        pclk,
    input  wire logic                        rst_n,
    input  wire lcd_pkg::axi_addr_t          aw_i,
    input  wire logic                        awvalid_i,
    output logic                             awready_o,
    input  wire lcd_pkg::axi_w_t             w_i,
    input  wire logic                        wvalid_i,
    output logic                             wready_o,
    output lcd_pkg::axi_b_t                  b_o,
    output logic                             bvalid_o,
    input  wire logic                        bready_i,
    input  wire lcd_pkg::axi_addr_t          ar_i,
    input  wire logic                        arvalid_i,
    output logic                             arready_o,
    output lcd_pkg::axi_r_t                  r_o,
    output logic                             rvalid_o,
    input  wire logic                        rready_i,
    input  wire logic [lcd_pkg::DATA_W-1:0]  touch_reg_i,
    input  wire logic                        cpu_work_i,
    input  wire logic                        write_ok_i,
    output lcd_pkg::lcd_cmd_t                buffer_cmd_o,
    output logic                             data_valid_o,
    output logic [lcd_pkg::DATA_W-1:0]       graph_size_o
);
    import lcd_pkg::*;

    lcd_cmd_t         wr_cmd;
    logic             wr_valid;
    logic             busy;
    logic             full;
    lcd_cmd_t         rd_cmd;
    logic [IDX_W-1:0] rd_idx;
    logic             release_frame;

    lcd_axi_slave u_axi_slave (
        .pclk, .rst_n,
        .aw_i, .awvalid_i, .awready_o,
        .w_i, .wvalid_i, .wready_o,
        .b_o, .bvalid_o, .bready_i,
        .ar_i, .arvalid_i, .arready_o,
        .r_o, .rvalid_o, .rready_i,
        .touch_reg_i,
        .busy_i     (busy),
        .wr_cmd_o   (wr_cmd),
        .wr_valid_o (wr_valid)
    );

    lcd_graph_buffer u_graph_buffer (
        .pclk, .rst_n, .cpu_work_i,
        .wr_cmd_i   (wr_cmd),
        .wr_valid_i (wr_valid),
        .rd_idx_i   (rd_idx),
        .release_i  (release_frame),
        .busy_o     (busy),
        .full_o     (full),
        .rd_cmd_o   (rd_cmd),
        .graph_size_o
    );

    lcd_dispatch u_dispatch (
        .pclk, .rst_n, .cpu_work_i,
        .full_i     (full),
        .rd_cmd_i   (rd_cmd),
        .write_ok_i,
        .rd_idx_o   (rd_idx),
        .buffer_cmd_o,
        .data_valid_o,
        .release_o  (release_frame)
    );

endmodule

`default_nettype wire

// ==== hdl/lcd_dispatch.sv ====
// sends the six buffered instructions to lcd_id, paced by write_ok
// a gap counter skips the write_ok still left over from the previous send
`timescale 1ns/1ps
`default_nettype none

module lcd_dispatch (
    input  wire logic                        pclk,
    input  wire logic                        rst_n,
    input  wire logic                        cpu_work_i,
    input  wire logic                        full_i,
    input  wire lcd_pkg::lcd_cmd_t           rd_cmd_i,
    input  wire logic                        write_ok_i,
    output logic [lcd_pkg::IDX_W-1:0]        rd_idx_o,
    output lcd_pkg::lcd_cmd_t                buffer_cmd_o,
    output logic                             data_valid_o,
    output logic                             release_o
);
    import lcd_pkg::*;

    logic [IDX_W-1:0] inst_q;   // instructions sent so far
    logic [GAP_W-1:0] gap_q;    // saturates at DISPATCH_GAP
    logic             gap_ok;
    logic             all_sent;
    logic             fire;

    assign gap_ok   = (gap_q == GAP_W'(DISPATCH_GAP));
    assign all_sent = (inst_q == IDX_W'(GRAPH_INSTS));
    // release_o still high means the buffer has not emptied yet
    assign fire     = full_i && gap_ok && write_ok_i && !release_o;
    assign rd_idx_o = inst_q;

    always_ff @(posedge pclk) begin
        if (!rst_n || !cpu_work_i) begin
            inst_q       <= '0;
            gap_q        <= GAP_W'(DISPATCH_GAP);
            data_valid_o <= 1'b0;
            release_o    <= 1'b0;
        end else begin
            data_valid_o <= 1'b0;
            release_o    <= 1'b0;
            if (!gap_ok) begin
                gap_q <= gap_q + 1'b1;
            end
            if (fire) begin
                if (all_sent) begin
                    inst_q    <= '0;
                    release_o <= 1'b1;  // frame done, free the buffer
                end else begin
                    inst_q       <= inst_q + 1'b1;
                    gap_q        <= '0;
                    data_valid_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (fire && !all_sent) buffer_cmd_o <= rd_cmd_i;
    end

    // the gap counter guarantees at least one idle cycle between sends
    a_valid_single: assert property (@(posedge pclk) disable iff (!rst_n)
        data_valid_o |=> !data_valid_o);

endmodule

`default_nettype wire

// ==== hdl/lcd_graph_buffer.sv ====
// holds one seven-word graph frame; only a write to the graph address opens it
// cpu_work low empties the buffer like reset
`timescale 1ns/1ps
`default_nettype none

module lcd_graph_buffer (
    input  wire logic                        pclk,
    input  wire logic                        rst_n,
    input  wire logic                        cpu_work_i,
    input  wire lcd_pkg::lcd_cmd_t           wr_cmd_i,
    input  wire logic                        wr_valid_i,
    input  wire logic [lcd_pkg::IDX_W-1:0]   rd_idx_i,
    input  wire logic                        release_i,
    output logic                             busy_o,
    output logic                             full_o,
    output lcd_pkg::lcd_cmd_t                rd_cmd_o,
    output logic [lcd_pkg::DATA_W-1:0]       graph_size_o
);
    import lcd_pkg::*;

    lcd_cmd_t         frame_q [GRAPH_WORDS];
    logic [IDX_W-1:0] cnt_q;   // next entry, 0 while no frame is open
    logic             full_q;
    logic             opens;
    logic             cap_en;

    assign opens  = (cnt_q == '0) && (wr_cmd_i.addr == ADDR_WRITE_GRAPH);
    assign cap_en = wr_valid_i && !full_q && ((cnt_q != '0) || opens);

    always_ff @(posedge pclk) begin
        if (!rst_n || !cpu_work_i) begin
            cnt_q  <= '0;
            full_q <= 1'b0;
        end else if (release_i) begin
            cnt_q  <= '0;
            full_q <= 1'b0;
        end else if (cap_en) begin
            if (cnt_q == IDX_W'(GRAPH_WORDS - 1)) begin
                cnt_q  <= '0;
                full_q <= 1'b1;  // seventh word in
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (cap_en) frame_q[cnt_q] <= wr_cmd_i;
    end

    // one flag, seen by the slave as busy and by the dispatcher as full
    assign busy_o = full_q;
    assign full_o = full_q;

    assign rd_cmd_o     = frame_q[rd_idx_i];
    assign graph_size_o = frame_q[GRAPH_WORDS - 1].data;  // last word is the size

    a_release_when_full: assert property (@(posedge pclk) disable iff (!rst_n)
        release_i |-> full_o);

endmodule

`default_nettype wire

// ==== hdl/lcd_pkg.sv ====
// address map, frame sizes and AXI channel types for the lcd controller
// single-beat AXI with 32-bit address and data only
`default_nettype none

package lcd_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    localparam logic [STRB_W-1:0] STRB_FULL = '1;
    localparam logic [1:0]        RESP_OKAY = 2'b00;

    // register map
    localparam logic [ADDR_W-1:0] ADDR_LCD_INPUT   = 32'h1fd0_c000; // touch register
    localparam logic [ADDR_W-1:0] ADDR_TOUCH_INPUT = 32'h1fd0_c004; // reads all ones
    localparam logic [ADDR_W-1:0] ADDR_WRITE_GRAPH = 32'h1fd0_c008; // opens a graph frame

    // graph frame: six panel instructions then the graph size word
    localparam int GRAPH_WORDS  = 7;
    localparam int GRAPH_INSTS  = 6;
    localparam int DISPATCH_GAP = 2;  // cycles between sends to lcd_id
    localparam int IDX_W        = 3;
    localparam int GAP_W        = 2;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } axi_addr_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } axi_r_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    // one instruction toward the panel side
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } lcd_cmd_t;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run, then judge the run from its log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module lcd_ctrl_tb -Mdir obj_dir -o lcd_sim &&
./obj_dir/lcd_sim | tee sim.log &&
grep -qx "test passed" sim.log || { echo "simulation did not pass"; exit 1; }

// ==== verif/lcd_ctrl_tb.sv ====
// table-driven AXI test of lcd_ctrl; the frame model counts full-strobe writes only
// a frame opens on the graph address and dispatches its first six pairs
`timescale 1ns/1ps
`default_nettype none

module lcd_ctrl_tb;
    import lcd_pkg::*;

    localparam int          TMO       = 200;
    localparam logic [31:0] TOUCH_VAL = 32'h0000_5a3c;

    typedef enum logic [2:0] {K_READ, K_WRITE, K_BURST, K_FLUSH, K_FRAME} kind_e;
    typedef struct packed {
        kind_e       kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] exp;    // read data, burst length or total log count
        logic [3:0]  stall;  // cycles bready stays low
    } row_t;

    logic pclk, rst_n, awvalid_i, awready_o, wvalid_i, wready_o, bvalid_o, bready_i;
    logic arvalid_i, arready_o, rvalid_o, rready_i, cpu_work_i, write_ok_i, data_valid_o;
    axi_addr_t   aw_i, ar_i;
    axi_w_t      w_i;
    axi_b_t      b_o;
    axi_r_t      r_o;
    lcd_cmd_t    buffer_cmd_o;
    logic [31:0] touch_reg_i, graph_size_o;

    int          err_cnt    = 0;
    int          pend_n     = 0;
    int          exp_total  = 0;
    logic [31:0] exp_size   = '0;
    logic        frame_done = 1'b0;
    lcd_cmd_t    pend [GRAPH_WORDS];
    lcd_cmd_t    exp_log [64];

    row_t tbl [24] = '{
        '{K_READ,  ADDR_LCD_INPUT,   32'h0,         4'h0, TOUCH_VAL,     4'd0},
        '{K_READ,  ADDR_TOUCH_INPUT, 32'h0,         4'h0, 32'hffff_ffff, 4'd0},
        '{K_READ,  ADDR_WRITE_GRAPH, 32'h0,         4'h0, 32'h0,         4'd0},
        '{K_READ,  32'h0000_1234,    32'h0,         4'h0, 32'h0,         4'd0},
        '{K_BURST, ADDR_WRITE_GRAPH, 32'ha000_0010, 4'hf, 32'd7,         4'd0},
        '{K_FRAME, 32'h0,            32'h0,         4'h0, 32'd6,         4'd0},
        '{K_WRITE, ADDR_WRITE_GRAPH, 32'hb000_0001, 4'hf, 32'h0,         4'd0},
        '{K_WRITE, 32'h1fd0_c020,    32'hb000_0002, 4'h3, 32'h0,         4'd0},
        '{K_BURST, 32'h1fd0_c030,    32'hb000_0100, 4'hf, 32'd5,         4'd0},
        '{K_WRITE, 32'h1fd0_c040,    32'hb000_0003, 4'h8, 32'h0,         4'd0},
        '{K_WRITE, 32'h1fd0_c044,    32'hb000_0004, 4'hf, 32'h0,         4'd1},
        '{K_FRAME, 32'h0,            32'h0,         4'h0, 32'd12,        4'd0},
        '{K_WRITE, 32'h1fd0_c100,    32'hc000_0001, 4'hf, 32'h0,         4'd0},
        '{K_WRITE, 32'h1fd0_c104,    32'hc000_0002, 4'h1, 32'h0,         4'd0},
        '{K_FRAME, 32'h0,            32'h0,         4'h0, 32'd12,        4'd0},
        '{K_BURST, ADDR_WRITE_GRAPH, 32'hd000_0020, 4'hf, 32'd7,         4'd0},
        '{K_WRITE, 32'h1fd0_c200,    32'he000_0001, 4'hf, 32'h0,         4'd3},
        '{K_FRAME, 32'h0,            32'h0,         4'h0, 32'd18,        4'd0},
        '{K_BURST, ADDR_WRITE_GRAPH, 32'hf000_0030, 4'hf, 32'd3,         4'd0},
        '{K_FLUSH, 32'h0,            32'h0,         4'h0, 32'h0,         4'd0},
        '{K_BURST, 32'h1fd0_c300,    32'h1100_0040, 4'hf, 32'd7,         4'd0},
        '{K_FRAME, 32'h0,            32'h0,         4'h0, 32'd18,        4'd0},
        '{K_BURST, ADDR_WRITE_GRAPH, 32'h2200_0050, 4'hf, 32'd7,         4'd0},
        '{K_FRAME, 32'h0,            32'h0,         4'h0, 32'd24,        4'd0}
    };

    lcd_ctrl u_dut (.*);

    lcd_id_model u_lcd_id (
        .pclk, .rst_n,
        .cmd_i        (buffer_cmd_o),
        .data_valid_i (data_valid_o),
        .write_ok_o   (write_ok_i)
    );

    initial begin
        pclk = 1'b0;
        forever #5 pclk = ~pclk;
    end

    task automatic check(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic abort_on_timeout(string what);
        $display("timeout: %s never came within %0d cycles", what, TMO);
        $display("errors: %0d", err_cnt);
        $display("test failed");
        $finish;
    endtask

    // frame rules applied to every completed full-strobe write
    task automatic capture(lcd_cmd_t c, logic [3:0] strb);
        if (strb != STRB_FULL || (pend_n == 0 && c.addr != ADDR_WRITE_GRAPH)) return;
        pend[pend_n] = c;
        pend_n++;
        if (pend_n == GRAPH_WORDS) begin
            for (int i = 0; i < GRAPH_INSTS; i++) exp_log[exp_total + i] = pend[i];
            exp_total += GRAPH_INSTS;
            exp_size   = c.data;
            pend_n     = 0;
            frame_done = 1'b1;
        end
    endtask

    task automatic axi_read(logic [31:0] addr, logic [31:0] exp);
        int t;
        ar_i      = '{addr: addr};
        arvalid_i = 1'b1;
        for (t = 0; !arready_o && t < TMO; t++) @(negedge pclk);
        if (t >= TMO) abort_on_timeout("arready");
        @(negedge pclk);
        arvalid_i = 1'b0;
        rready_i  = 1'b1;
        for (t = 0; !rvalid_o && t < TMO; t++) @(negedge pclk);
        if (t >= TMO) abort_on_timeout("rvalid");
        check("r_o.data", r_o.data, exp);
        check("r_o.resp", r_o.resp, RESP_OKAY);
        check("r_o.last", r_o.last, 1'b1);  // single beat
        @(negedge pclk);
        rready_i = 1'b0;
    endtask

    task automatic axi_write(logic [31:0] addr, logic [31:0] data, logic [3:0] strb, int stall);
        int t;
        aw_i      = '{addr: addr};
        awvalid_i = 1'b1;
        for (t = 0; !awready_o && t < TMO; t++) @(negedge pclk);
        if (t >= TMO) abort_on_timeout("awready");
        if (frame_done) check("log count at AW accept", u_lcd_id.log_cnt, exp_total);
        frame_done = 1'b0;
        @(negedge pclk);
        awvalid_i = 1'b0;
        w_i       = '{data, strb, 1'b1};
        wvalid_i  = 1'b1;
        for (t = 0; !wready_o && t < TMO; t++) @(negedge pclk);
        if (t >= TMO) abort_on_timeout("wready");
        @(negedge pclk);
        wvalid_i = 1'b0;
        capture(lcd_cmd_t'{addr, data}, strb);
        for (t = 0; !bvalid_o && t < TMO; t++) @(negedge pclk);
        if (t >= TMO) abort_on_timeout("bvalid");
        repeat (stall) begin
            @(negedge pclk);
            check("bvalid_o", bvalid_o, 1'b1);  // held while bready low
        end
        bready_i = 1'b1;
        check("b_o.resp", b_o.resp, RESP_OKAY);
        @(negedge pclk);
        bready_i = 1'b0;
    endtask

    task automatic expect_frame(int n);
        int t;
        for (t = 0; u_lcd_id.log_cnt < n && t < TMO; t++) @(negedge pclk);
        if (t >= TMO) abort_on_timeout("frame dispatch to lcd_id");
        repeat (20) @(negedge pclk);  // room for any stray send
        check("lcd_id log count", u_lcd_id.log_cnt, n);
        for (int i = 0; i < n; i++) check("lcd_id command", u_lcd_id.log_mem[i], exp_log[i]);
        frame_done = 1'b0;
    endtask

    always @(negedge pclk) begin
        if (rst_n && data_valid_o) check("graph_size_o", graph_size_o, exp_size);
    end

    initial begin
        rst_n       = 1'b0;
        aw_i        = '0;
        ar_i        = '0;
        w_i         = '0;
        awvalid_i   = 1'b0;
        wvalid_i    = 1'b0;
        bready_i    = 1'b0;
        arvalid_i   = 1'b0;
        rready_i    = 1'b0;
        touch_reg_i = TOUCH_VAL;
        cpu_work_i  = 1'b1;
        repeat (8) @(negedge pclk);
        rst_n = 1'b1;
        @(negedge pclk);
        for (int i = 0; i < $size(tbl); i++) begin
            case (tbl[i].kind)
                K_READ:  axi_read(tbl[i].addr, tbl[i].exp);
                K_WRITE: axi_write(tbl[i].addr, tbl[i].data, tbl[i].strb, tbl[i].stall);
                K_BURST: for (int j = 0; j < tbl[i].exp; j++)
                    axi_write(tbl[i].addr + 4 * j, tbl[i].data + j, STRB_FULL, 0);
                K_FLUSH: begin
                    cpu_work_i = 1'b0;
                    @(negedge pclk);
                    cpu_work_i = 1'b1;
                    pend_n     = 0;
                end
                default: expect_frame(tbl[i].exp);
            endcase
        end
        repeat (5) @(negedge pclk);
        $display("errors: %0d", err_cnt);
        if (err_cnt == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/lcd_id_model.sv ====
// panel-side responder standing in for lcd_id; write_ok drops 1 to 4 cycles per word
// logs at most 64 commands, later ones wrap over the oldest
`timescale 1ns/1ps
`default_nettype none

module lcd_id_model (
    input  wire logic               pclk,
    input  wire logic               rst_n,
    input  wire lcd_pkg::lcd_cmd_t  cmd_i,
    input  wire logic               data_valid_i,
    output logic                    write_ok_o
);
    import lcd_pkg::*;

    lcd_cmd_t   log_mem [64];
    int         log_cnt;
    logic [7:0] lfsr_q;
    logic [7:0] lfsr_1;
    logic [7:0] lfsr_2;
    logic [2:0] hold_q;  // cycles left with write_ok low

    // fibonacci, taps 8 6 5 4, new bit enters at the bottom
    function automatic logic [7:0] lfsr_step(logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    assign lfsr_1 = lfsr_step(lfsr_q);
    assign lfsr_2 = lfsr_step(lfsr_1);

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            lfsr_q     <= 8'd54;
            hold_q     <= '0;
            write_ok_o <= 1'b1;
            log_cnt    <= 0;
        end else if (data_valid_i) begin
            log_mem[log_cnt[5:0]] <= cmd_i;
            log_cnt    <= log_cnt + 1;
            lfsr_q     <= lfsr_2;  // two bits taken
            hold_q     <= {1'b0, lfsr_1[0], lfsr_2[0]} + 3'd1;
            write_ok_o <= 1'b0;
        end else if (hold_q != '0) begin
            hold_q <= hold_q - 3'd1;
            if (hold_q == 3'd1) write_ok_o <= 1'b1;
        end
    end

endmodule

`default_nettype wire
